/* source/adam_front_pkg.sv */
// Shared widths, keypad codes and bus structs for the console front end
// All pad bits in joy_t are active high, port select and reply lines are
// active low as the console drives and samples them

package adam_front_pkg;

        // ====================
        // Widths and constants
        // ====================
        localparam int DL_ADDR_W  = 25;
        localparam int DL_INDEX_W = 8;
        localparam int PAGE_W     = 6;

        // Low five index bits of an SG-1000 image
        localparam logic [4:0] SG1000_INDEX = 5'd2;

        // Address bits 24..13 of the 2000..3FFF window
        localparam logic [DL_ADDR_W-14:0] EXTRAM_BLOCK = 1;

        // Controller line codes as read back by the console
        typedef enum logic [3:0] {
                KEY_0      = 4'b0011,
                KEY_1      = 4'b1110,
                KEY_2      = 4'b1101,
                KEY_3      = 4'b0110,
                KEY_4      = 4'b0001,
                KEY_5      = 4'b1001,
                KEY_6      = 4'b0111,
                KEY_7      = 4'b1100,
                KEY_8      = 4'b1000,
                KEY_9      = 4'b1011,
                KEY_STAR   = 4'b1010,
                KEY_HASH   = 4'b0101,
                KEY_PURPLE = 4'b0100,
                KEY_BLUE   = 4'b0010,
                KEY_NONE   = 4'b1111
        } key_code_e;

        // ====================
        // Bus structs
        // ====================

        // One player pad, bit n of digit is key n
        typedef struct packed {
                logic       blue;
                logic       purple;
                logic [9:0] digit;
                logic       hash;
                logic       star;
                logic       fire2;
                logic       fire1;
                logic       up;
                logic       down;
                logic       left;
                logic       right;
        } joy_t;

        // Download stream, data byte travels on its own port
        typedef struct packed {
                logic                  active;
                logic [DL_INDEX_W-1:0] index;
                logic                  wr;
                logic [DL_ADDR_W-1:0]  addr;
        } dl_bus_t;

        typedef struct packed {
                logic              sg1000;
                logic              extram;
                logic [PAGE_W-1:0] pages;
        } cart_info_t;

        // Console strobes for one controller port
        typedef struct packed {
                logic key_sel_n;
                logic joy_sel_n;
        } port_sel_t;

        typedef struct packed {
                logic [3:0] data;
                logic       fire_n;
        } port_lines_t;

endpackage

/* source/clock_enables.sv */
// Clock enable strobes for the 10.7 MHz and 5.3 MHz domains
// Strobes are one clk_sys cycle wide, every 4th and every 8th cycle
// The 5.3 MHz strobe always coincides with a 10.7 MHz strobe

`timescale 1ns/1ps

module clock_enables (
        input  logic clk_sys,
        input  logic reset_i,
        output logic ce_10m7_o,
        output logic ce_5m3_o
);

        logic [2:0] div_q;

        // Free-running divider, strobes decoded from its previous value
        always_ff @(posedge clk_sys) begin
                if (reset_i) begin
                        div_q     <= '0;
                        ce_10m7_o <= 1'b0;
                        ce_5m3_o  <= 1'b0;
                end else begin
                        div_q     <= div_q + 3'd1;
                        ce_10m7_o <= (div_q[1:0] == 2'b00);
                        ce_5m3_o  <= (div_q == 3'b000);
                end
        end

endmodule

/* source/cart_loader.sv */
// Tracks a cartridge download and records mode, extra RAM and page count
// Only cycles with dl_i.wr high are looked at; results show one cycle later
// Extra RAM is detected only on SG-1000 images, when the whole 2000..3FFF
// window was written with FF from its first byte on

`timescale 1ns/1ps

module cart_loader (
        input  logic                  clk_sys,
        input  logic                  reset_i,
        input  adam_front_pkg::dl_bus_t dl_i,
        input  logic [7:0]            dl_data_i,
        output adam_front_pkg::cart_info_t cart_o
);

        import adam_front_pkg::*;

        cart_info_t cart_q;

        logic addr_zero;
        logic in_ext_window;
        logic window_start;
        logic data_ff;

        // ====================
        // Address decode
        // ====================
        assign addr_zero     = (dl_i.addr == '0);
        assign in_ext_window = (dl_i.addr[DL_ADDR_W-1:13] == EXTRAM_BLOCK);
        assign window_start  = (dl_i.addr[12:0] == 13'd0);
        assign data_ff       = &dl_data_i;

        // ====================
        // Cartridge state
        // ====================
        always_ff @(posedge clk_sys) begin
                if (reset_i) begin
                        cart_q <= '0;
                end else if (dl_i.wr) begin
                        // 16K page of the latest write
                        cart_q.pages <= dl_i.addr[14+PAGE_W-1:14];

                        // New image starts at address zero
                        if (addr_zero) begin
                                cart_q.extram <= 1'b0;
                                cart_q.sg1000 <= (dl_i.index[4:0] == SG1000_INDEX);
                        end

                        // SG-1000 window stays extra RAM only while all bytes are FF
                        if (in_ext_window && cart_q.sg1000) begin
                                cart_q.extram <= (window_start | cart_q.extram) & data_ff;
                        end
                end
        end

        assign cart_o = cart_q;

endmodule

/* source/keypad_encoder.sv */
// Controller port encoder for one player, purely combinational
// Keypad branch is active while key_sel_n is low, joystick branch while
// joy_sel_n is low; an inactive branch reads as all ones
// Keypad priority is digits 0..9, star, hash, purple, blue

`timescale 1ns/1ps

module keypad_encoder (
        input  adam_front_pkg::joy_t        pad_i,
        input  adam_front_pkg::port_sel_t   sel_i,
        output adam_front_pkg::port_lines_t lines_o
);

        import adam_front_pkg::*;

        logic [13:0] key_vec;
        key_code_e   key_code;

        logic [3:0] key_term;
        logic [3:0] joy_term;
        logic       key_fire_n;
        logic       joy_fire_n;

        // Line code for a position in key_vec
        function automatic key_code_e code_of(input int pos);
                key_code_e code;

                case (pos)
                        0:       code = KEY_0;
                        1:       code = KEY_1;
                        2:       code = KEY_2;
                        3:       code = KEY_3;
                        4:       code = KEY_4;
                        5:       code = KEY_5;
                        6:       code = KEY_6;
                        7:       code = KEY_7;
                        8:       code = KEY_8;
                        9:       code = KEY_9;
                        10:      code = KEY_STAR;
                        11:      code = KEY_HASH;
                        12:      code = KEY_PURPLE;
                        13:      code = KEY_BLUE;
                        default: code = KEY_NONE;
                endcase
                return code;
        endfunction

        // ====================
        // Keypad branch
        // ====================

        // Bit 0 has the highest priority
        assign key_vec = {pad_i.blue, pad_i.purple, pad_i.hash, pad_i.star, pad_i.digit};

        // Walk from lowest to highest priority so the first pressed key wins
        always_comb begin
                key_code = KEY_NONE;
                for (int i = 13; i >= 0; i--) begin
                        if (key_vec[i]) begin
                                key_code = code_of(i);
                        end
                end
        end

        always_comb begin
                key_term   = 4'b1111;
                key_fire_n = 1'b1;
                if (!sel_i.key_sel_n) begin
                        key_term   = key_code;
                        key_fire_n = ~pad_i.fire2;
                end
        end

        // ====================
        // Joystick branch
        // ====================
        always_comb begin
                joy_term   = 4'b1111;
                joy_fire_n = 1'b1;
                if (!sel_i.joy_sel_n) begin
                        joy_term   = ~{pad_i.up, pad_i.down, pad_i.left, pad_i.right};
                        joy_fire_n = ~pad_i.fire1;
                end
        end

        // Both branches share the open-collector style lines
        assign lines_o.data   = key_term & joy_term;
        assign lines_o.fire_n = key_fire_n & joy_fire_n;

endmodule

/* source/sync_conditioner.sv */
// Turns the active-low video syncs into positive pulses
// hs_o lags hsync by one cycle; vs_o is updated only on the first cycle
// of a horizontal sync so its edges fall inside hsync

`timescale 1ns/1ps

module sync_conditioner (
        input  logic clk_sys,
        input  logic reset_i,
        input  logic hsync_n_i,
        input  logic vsync_n_i,
        output logic hs_o,
        output logic vs_o
);

        logic hs_q;
        logic vs_q;
        logic vs_update;

        // Hsync just went active while the registered copy is still idle
        assign vs_update = ~hs_q & ~hsync_n_i;

        always_ff @(posedge clk_sys) begin
                if (reset_i) begin
                        hs_q <= 1'b0;
                        vs_q <= 1'b0;
                end else begin
                        hs_q <= ~hsync_n_i;
                        if (vs_update) begin
                                vs_q <= ~vsync_n_i;
                        end
                end
        end

        assign hs_o = hs_q;
        assign vs_o = vs_q;

endmodule

/* source/adam_front_top.sv */
// Console-side front end top level
// sys_reset_o is combinational: external reset, user reset or a download
// Submodules are cleared by reset_i only, so download tracking survives
// the reset that a download itself raises
// swap_i exchanges the two pads between the controller ports

`timescale 1ns/1ps

module adam_front_top (
        input  logic                              clk_sys,
        input  logic                              reset_i,
        input  logic                              user_reset_i,

        // Download stream
        input  adam_front_pkg::dl_bus_t           dl_i,
        input  logic [7:0]                        dl_data_i,

        // Pads and controller ports
        input  logic                              swap_i,
        input  adam_front_pkg::joy_t              joy_a_i,
        input  adam_front_pkg::joy_t              joy_b_i,
        input  adam_front_pkg::port_sel_t   [1:0] sel_i,

        // Video syncs, active low from the video chip
        input  logic                              hsync_n_i,
        input  logic                              vsync_n_i,

        output logic                              sys_reset_o,
        output logic                              ce_10m7_o,
        output logic                              ce_5m3_o,
        output adam_front_pkg::cart_info_t        cart_o,
        output adam_front_pkg::port_lines_t [1:0] lines_o,
        output logic                              hs_o,
        output logic                              vs_o
);

        import adam_front_pkg::*;

        joy_t pad0;
        joy_t pad1;

        // ====================
        // Reset and player swap
        // ====================
        assign sys_reset_o = reset_i | user_reset_i | dl_i.active;

        assign pad0 = swap_i ? joy_b_i : joy_a_i;
        assign pad1 = swap_i ? joy_a_i : joy_b_i;

        // ====================
        // Instances
        // ====================
        clock_enables u_clock_enables (
                .clk_sys   (clk_sys),
                .reset_i   (reset_i),
                .ce_10m7_o (ce_10m7_o),
                .ce_5m3_o  (ce_5m3_o)
        );

        cart_loader u_cart_loader (
                .clk_sys   (clk_sys),
                .reset_i   (reset_i),
                .dl_i      (dl_i),
                .dl_data_i (dl_data_i),
                .cart_o    (cart_o)
        );

        keypad_encoder u_port0 (
                .pad_i   (pad0),
                .sel_i   (sel_i[0]),
                .lines_o (lines_o[0])
        );

        keypad_encoder u_port1 (
                .pad_i   (pad1),
                .sel_i   (sel_i[1]),
                .lines_o (lines_o[1])
        );

        sync_conditioner u_sync_conditioner (
                .clk_sys   (clk_sys),
                .reset_i   (reset_i),
                .hsync_n_i (hsync_n_i),
                .vsync_n_i (vsync_n_i),
                .hs_o      (hs_o),
                .vs_o      (vs_o)
        );

endmodule

/* sim/tb_adam_front_ref.svh */
// Reference models for the controller port lines and the cartridge tracking
// Included inside the testbench module after the package import

`ifndef TB_ADAM_FRONT_REF_SVH
`define TB_ADAM_FRONT_REF_SVH

// Digit codes, nibble n holds the code of digit n
localparam logic [39:0] DIGIT_CODES = {4'b1011, 4'b1000, 4'b1100, 4'b0111, 4'b1001,
                                       4'b0001, 4'b0110, 4'b1101, 4'b1110, 4'b0011};

// First pressed key wins: digits 0..9, star, hash, purple, blue
function automatic logic [3:0] ref_key_code(input joy_t pad);
        logic [3:0] code;
        logic       found;

        code  = 4'b1111;
        found = 1'b0;
        for (int d = 0; d < 10; d++) begin
                if (!found && pad.digit[d]) begin
                        code  = DIGIT_CODES[d*4 +: 4];
                        found = 1'b1;
                end
        end
        if (!found) begin
                if (pad.star)        code = 4'b1010;
                else if (pad.hash)   code = 4'b0101;
                else if (pad.purple) code = 4'b0100;
                else if (pad.blue)   code = 4'b0010;
        end
        return code;
endfunction

function automatic port_lines_t ref_encode(input joy_t pad, input port_sel_t sel);
        port_lines_t res;

        res.data   = 4'b1111;
        res.fire_n = 1'b1;
        if (!sel.key_sel_n) begin
                res.data   = ref_key_code(pad);
                res.fire_n = !pad.fire2;
        end
        // Joystick branch pulls lines low on top of the keypad branch
        if (!sel.joy_sel_n) begin
                res.data   = res.data & {!pad.up, !pad.down, !pad.left, !pad.right};
                res.fire_n = res.fire_n & !pad.fire1;
        end
        return res;
endfunction

// Next cartridge state after one write of the download stream
function automatic cart_info_t ref_cart(input cart_info_t prev, input logic [24:0] addr,
                                        input logic [7:0] index, input logic [7:0] data);
        cart_info_t next;

        next       = prev;
        next.pages = addr[19:14];
        if (addr == 25'd0) begin
                next.extram = 1'b0;
                next.sg1000 = (index[4:0] == SG1000_INDEX);
        end else if (addr[24:13] == EXTRAM_BLOCK && prev.sg1000) begin
                next.extram = ((addr[12:0] == 13'd0) || prev.extram) && (data == 8'hff);
        end
        return next;
endfunction

`endif

/* sim/tb_adam_front.sv */
// Testbench for the console front end top level
// Inputs change on the rising edge, outputs are compared on the falling edge
// Most of the run time goes into three downloads with a full 8K window each

`timescale 1ns/1ps

module tb_adam_front;

        import adam_front_pkg::*;

        `include "tb_adam_front_ref.svh"

        localparam int     HEAD_BYTES = 64;
        localparam int     WIN_BYTES  = 8192;
        localparam int     DL_WRITES  = HEAD_BYTES + WIN_BYTES + 63;
        // A write may be preceded by one idle cycle, hence the factor of two
        localparam int     TOTAL_CYC  = 10 + 40 + 200 + 200 + 40 + 3 * (2 * DL_WRITES + 8)
                                        + 20 + 30 * 16 + 10;
        localparam longint TIMEOUT_NS = longint'(TOTAL_CYC) * 10 + 2000;

        logic                clk_sys;
        logic                reset;
        logic                user_reset;
        dl_bus_t             dl;
        logic [7:0]          dl_data;
        logic                swap;
        joy_t                joy_a;
        joy_t                joy_b;
        port_sel_t     [1:0] sel;
        logic                hsync_n;
        logic                vsync_n;
        logic                sys_reset;
        logic                ce_10m7;
        logic                ce_5m3;
        cart_info_t          cart;
        port_lines_t   [1:0] lines;
        logic                hs;
        logic                vs;

        integer      seed;
        logic [31:0] rnd;
        int          errors;
        int          errors_at_start;
        int          test_num;
        int          tests_passed;
        int          tests_failed;
        logic        port_chk;
        logic        cart_chk;
        logic        sync_chk;
        cart_info_t  exp_cart;
        port_lines_t exp_lines;
        logic        exp_hs;
        logic        exp_vs;

        adam_front_top i_dut (
                .clk_sys      (clk_sys),
                .reset_i      (reset),
                .user_reset_i (user_reset),
                .dl_i         (dl),
                .dl_data_i    (dl_data),
                .swap_i       (swap),
                .joy_a_i      (joy_a),
                .joy_b_i      (joy_b),
                .sel_i        (sel),
                .hsync_n_i    (hsync_n),
                .vsync_n_i    (vsync_n),
                .sys_reset_o  (sys_reset),
                .ce_10m7_o    (ce_10m7),
                .ce_5m3_o     (ce_5m3),
                .cart_o       (cart),
                .lines_o      (lines),
                .hs_o         (hs),
                .vs_o         (vs)
        );

        initial clk_sys = 1'b0;
        always #5 clk_sys = ~clk_sys;

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
                if (got !== exp) begin
                        errors++;
                        $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
                end
        endtask

        task automatic start_test();
                errors_at_start = errors;
        endtask

        task automatic finish_test(input string name);
                test_num++;
                if (errors == errors_at_start) begin
                        tests_passed++;
                        $display("test %0d %s: ok", test_num, name);
                end else begin
                        tests_failed++;
                        $display("test %0d %s: %0d mismatches", test_num, name,
                                 errors - errors_at_start);
                end
        endtask

        // Mode 0 any keys, mode 1 no key at all, mode 2 exactly one key
        function automatic joy_t random_pad(input int mode);
                logic [31:0] r;
                joy_t        pad;

                r   = $random(seed);
                pad = r[19:0];
                if (mode == 1) begin
                        pad[19:6] = '0;
                end else if (mode == 2) begin
                        pad[19:6] = 14'd1 << (r[27:24] % 14);
                end
                return pad;
        endfunction

        task automatic dl_write(input logic [24:0] addr, input logic [7:0] data);
                logic [31:0] r;

                r = $random(seed);
                if (r[1:0] == 2'b00) begin
                        @(posedge clk_sys);
                        dl.wr <= 1'b0;
                end
                @(posedge clk_sys);
                dl.wr   <= 1'b1;
                dl.addr <= addr;
                dl_data <= data;
        endtask

        // Header bytes, the 2000..3FFF window, then one write per 16K page
        task automatic run_download(input logic [7:0] index, input int bad_off);
                logic [31:0] r;

                @(posedge clk_sys);
                dl.active <= 1'b1;
                dl.index  <= index;
                for (int a = 0; a < HEAD_BYTES; a++) begin
                        r = $random(seed);
                        dl_write(25'(a), r[7:0]);
                end
                for (int a = 0; a < WIN_BYTES; a++) begin
                        dl_write(25'(32'h2000 + a), (a == bad_off) ? 8'h5a : 8'hff);
                end
                for (int pg = 1; pg < 64; pg++) begin
                        r = $random(seed);
                        dl_write(25'(pg * 32'h4000), r[7:0]);
                end
                @(posedge clk_sys);
                dl.wr <= 1'b0;
                @(posedge clk_sys);
                dl.active <= 1'b0;
                @(negedge clk_sys);
        endtask

        // ====================
        // Reference state
        // ====================
        always @(posedge clk_sys) begin
                if (reset) begin
                        exp_cart <= '0;
                        exp_hs   <= 1'b0;
                        exp_vs   <= 1'b0;
                end else begin
                        if (dl.wr) begin
                                exp_cart <= ref_cart(exp_cart, dl.addr, dl.index, dl_data);
                        end
                        exp_hs <= !hsync_n;
                        // Vsync is taken only at the start of a horizontal sync
                        if (!exp_hs && !hsync_n) begin
                                exp_vs <= !vsync_n;
                        end
                end
        end

        // ====================
        // Compare
        // ====================
        always @(negedge clk_sys) begin
                if (port_chk) begin
                        for (int p = 0; p < 2; p++) begin
                                exp_lines = ref_encode((swap ^ (p == 1)) ? joy_b : joy_a, sel[p]);
                                check_value($sformatf("lines_o[%0d]", p), 32'(lines[p]),
                                            32'(exp_lines));
                        end
                end
                if (cart_chk) begin
                        check_value("cart_o", 32'(cart), 32'(exp_cart));
                        check_value("sys_reset_o", 32'(sys_reset),
                                    32'(reset | user_reset | dl.active));
                end
                if (sync_chk) begin
                        check_value("hs_o", 32'(hs), 32'(exp_hs));
                        check_value("vs_o", 32'(vs), 32'(exp_vs));
                end
        end

        initial begin
                #(TIMEOUT_NS);
                $display("timeout: the run did not complete within %0d ns", TIMEOUT_NS);
                $display("tests failed");
                $finish;
        end

        initial begin
                seed         = 32'h5bb2_5086;
                errors       = 0;
                test_num     = 0;
                tests_passed = 0;
                tests_failed = 0;
                port_chk     = 1'b0;
                cart_chk     = 1'b0;
                sync_chk     = 1'b0;
                reset      <= 1'b1;
                user_reset <= 1'b0;
                dl         <= '0;
                dl_data    <= 8'h00;
                swap       <= 1'b0;
                joy_a      <= '0;
                joy_b      <= '0;
                sel        <= '1;
                hsync_n    <= 1'b1;
                vsync_n    <= 1'b1;
                repeat (10) @(posedge clk_sys);
                reset <= 1'b0;

                // First 10.7 MHz strobe lands in the second cycle after release
                start_test();
                for (int n = 0; n < 40; n++) begin
                        @(negedge clk_sys);
                        check_value("ce_10m7_o", 32'(ce_10m7), 32'(n % 4 == 1));
                        check_value("ce_5m3_o", 32'(ce_5m3), 32'(n % 8 == 1));
                        if (ce_5m3 && !ce_10m7) begin
                                errors++;
                                $display("ce_5m3_o pulsed at %0t ns without ce_10m7_o", $time);
                        end
                end
                finish_test("clock enables");

                start_test();
                for (int i = 0; i < 200; i++) begin
                        @(posedge clk_sys);
                        joy_a    <= random_pad(i % 3);
                        joy_b    <= random_pad((i + 1) % 3);
                        sel      <= 4'b0101;
                        port_chk  = 1'b1;
                end
                @(posedge clk_sys);
                port_chk = 1'b0;
                finish_test("keypad encoding");

                // Port 1 runs the select combinations in the opposite order
                start_test();
                for (int i = 0; i < 200; i++) begin
                        @(posedge clk_sys);
                        joy_a    <= random_pad(i % 3);
                        joy_b    <= random_pad((i + 2) % 3);
                        sel      <= {2'(3 - i / 50), 2'(i / 50)};
                        port_chk  = 1'b1;
                end
                @(posedge clk_sys);
                port_chk = 1'b0;
                finish_test("joystick and combined selects");

                start_test();
                for (int i = 0; i < 40; i++) begin
                        @(posedge clk_sys);
                        rnd = $random(seed);
                        // Pad a has digit 3, up and fire1; pad b has hash, right and fire2
                        joy_a    <= 20'h00818;
                        joy_b    <= 20'h000a1;
                        swap     <= i[0];
                        sel      <= rnd[3:0];
                        port_chk  = 1'b1;
                end
                @(posedge clk_sys);
                port_chk = 1'b0;
                swap    <= 1'b0;
                finish_test("player swap");

                start_test();
                @(posedge clk_sys);
                cart_chk = 1'b1;
                run_download(8'd2, -1);
                check_value("cart_o.sg1000", 32'(cart.sg1000), 32'd1);
                check_value("cart_o.extram", 32'(cart.extram), 32'd1);
                check_value("cart_o.pages", 32'(cart.pages), 32'd63);
                @(posedge clk_sys);
                user_reset <= 1'b1;
                repeat (4) @(posedge clk_sys);
                user_reset <= 1'b0;
                run_download(8'd2, 32'h123);
                check_value("cart_o.extram", 32'(cart.extram), 32'd0);
                run_download(8'd1, -1);
                check_value("cart_o.sg1000", 32'(cart.sg1000), 32'd0);
                check_value("cart_o.extram", 32'(cart.extram), 32'd0);
                @(posedge clk_sys);
                cart_chk = 1'b0;
                finish_test("cartridge download");

                // 16-cycle lines with hsync low in cycles 2..5, vsync toggles every other line
                start_test();
                @(posedge clk_sys);
                sync_chk = 1'b1;
                for (int ln = 0; ln < 30; ln++) begin
                        rnd = $random(seed);
                        for (int c = 0; c < 16; c++) begin
                                @(posedge clk_sys);
                                hsync_n <= !(c >= 2 && c < 6);
                                if (ln % 2 == 0 && c == ((ln % 4 == 0) ? 3 : int'(rnd[3:0]))) begin
                                        vsync_n <= !vsync_n;
                                end
                        end
                end
                @(posedge clk_sys);
                sync_chk = 1'b0;
                finish_test("sync conditioning");

                $display("%0d tests run, %0d passed, %0d failed, %0d mismatches", test_num,
                         tests_passed, tests_failed, errors);
                if (errors == 0 && tests_failed == 0) begin
                        $display("all tests passed");
                end else begin
                        $display("tests failed");
                end
                $finish;
        end

endmodule

/* tb.f */
+incdir+sim
source/adam_front_pkg.sv
source/clock_enables.sv
source/cart_loader.sv
source/keypad_encoder.sv
source/sync_conditioner.sv
source/adam_front_top.sv
sim/tb_adam_front.sv

/* run_sim.sh */
#!/bin/sh
# Builds the front-end testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -j 0 -f tb.f --top-module tb_adam_front -o tb_adam_front_sim

status=0
./obj_dir/tb_adam_front_sim > "$LOG" 2>&1 || status=$?
cat "$LOG"

if [ "$status" -ne 0 ] || grep -q "tests failed" "$LOG"; then
        echo "simulation FAILED, see $LOG"
        exit 1
fi
echo "simulation passed"
exit 0
